/* flist.f */
+incdir+tb
common/noc_flit_pkg.sv
common/mesh_topo_pkg.sv
router/router_in_buffer.sv
router/router_route_xy.sv
router/router_out_arbiter.sv
router/mesh_router.sv
source/mesh_noc.sv
tb/tb_mesh_noc.sv

/* tb/mesh_vectors.txt */
// One hex digit each: test, source node, destination node, length, ready mask
// Ready mask bits are picked at random each cycle for the destination's local output
2_0_0_1_f
2_0_1_1_f
2_0_2_1_f
2_0_3_1_f
2_1_0_1_f
2_1_1_1_f
2_1_2_1_f
2_1_3_1_f
2_2_0_1_f
2_2_1_1_f
2_2_2_1_f
2_2_3_1_f
2_3_0_1_f
2_3_1_1_f
2_3_2_1_f
2_3_3_1_f
3_0_3_4_f
3_1_2_3_f
3_3_0_5_f
3_2_1_2_f
4_0_3_2_f
4_0_3_2_f
4_0_3_2_f
4_2_1_1_f
4_2_1_3_f
5_0_2_3_f
5_1_2_3_f
5_2_2_2_f
5_3_2_4_f
6_0_3_4_5
6_1_3_2_5
6_2_0_3_9
6_3_1_1_3

/* tb/tb_mesh_checks.svh */
task automatic check_flit(input string name, input noc_flit_pkg::noc_flit_t got,
                          input noc_flit_pkg::noc_flit_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
   end
endtask

// Flit only matters while valid is expected
task automatic check_link(input string name, input noc_flit_pkg::noc_link_t got,
                          input noc_flit_pkg::noc_link_t exp);
   checks++;
   if (got.valid !== exp.valid || (exp.valid && got.flit !== exp.flit)) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
   end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
   end
endtask

task automatic check_count(input string name, input int got, input int exp);
   checks++;
   if (got != exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
   end
endtask

// Galois LFSR, one step per bit taken
function automatic logic [31:0] next_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
      r = {r[30:0], lfsr_state[0]};
   end
   return r;
endfunction

/* tb/tb_mesh_noc.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mesh_noc;

   localparam int xdim  = 2;
   localparam int ydim  = 2;
   localparam int nodes = xdim * ydim;

   logic                    clk_i = 1'b0;
   logic                    rst_n_i;
   noc_flit_pkg::noc_link_t local_in_i        [nodes];
   logic                    local_in_ready_o  [nodes];
   noc_flit_pkg::noc_link_t local_out_o       [nodes];
   logic                    local_out_ready_i [nodes];

   logic [19:0]             vec [64];  // test_src_dst_len_mask
   int                      num_vec;
   int                      total_flits;
   int                      errors = 0;
   int                      checks = 0;
   int                      rx_pkts;
   logic [15:0]             lfsr_state = 16'd35;
   bit                      running = 1'b0;
   noc_flit_pkg::noc_flit_t send_q [nodes][$];
   noc_flit_pkg::noc_flit_t exp_q  [nodes*nodes][$];  // dst*nodes + src
   int                      cur_src [nodes];
   logic [3:0]              stall_mask [nodes];
   bit                      fire [nodes];
   bit                      held_vld [nodes];
   noc_flit_pkg::noc_link_t held [nodes];
   string                   test_name [7] = '{"", "reset state", "unicast delivery",
      "wormhole integrity", "ordering", "contention", "back-pressure"};

   `include "tb_mesh_checks.svh"

   mesh_noc #(
      .xdim       (xdim),
      .ydim       (ydim),
      .fifo_depth (4)
   ) mesh_noc_inst (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .local_in_i        (local_in_i),
      .local_in_ready_o  (local_in_ready_o),
      .local_out_o       (local_out_o),
      .local_out_ready_i (local_out_ready_i)
   );

   always #5 clk_i = ~clk_i;

   // Build packets of one test into the send and expected queues
   task automatic load_test(input int g, output int n_pkts);
      noc_flit_pkg::noc_flit_t f;
      logic [3:0]              src;
      logic [3:0]              dst;
      int                      len;
      logic [31:0]             r;
      n_pkts = 0;
      for (int v = 0; v < num_vec; v++) begin
         if (int'(vec[v][19:16]) == g) begin
            src = vec[v][15:12];
            dst = vec[v][11:8];
            len = int'(vec[v][7:4]);
            stall_mask[dst] = vec[v][3:0];
            for (int k = 0; k < len; k++) begin
               if (len == 1) f.kind = noc_flit_pkg::flit_single;
               else if (k == 0) f.kind = noc_flit_pkg::flit_head;
               else if (k == len - 1) f.kind = noc_flit_pkg::flit_tail;
               else f.kind = noc_flit_pkg::flit_body;
               if (k == 0) begin
                  r = next_bits(24);
                  f.data = {r[23:0], src, dst};  // Source tag above destination
               end else begin
                  f.data = next_bits(32);
               end
               send_q[src].push_back(f);
               exp_q[dst*nodes + src].push_back(f);
            end
            n_pkts++;
         end
      end
   endtask

   task automatic receive_flit(input int n, input noc_flit_pkg::noc_flit_t f);
      int    src;
      int    q;
      string name;
      name = $sformatf("local_out_o[%0d].flit", n);
      if (cur_src[n] < 0) begin
         src = int'(f.data[7:4]);
         if (f.kind == noc_flit_pkg::flit_body || f.kind == noc_flit_pkg::flit_tail) begin
            errors++;
            $display("node %0d delivered a body or tail flit outside any packet", n);
         end else if (src >= nodes || exp_q[n*nodes + src].size() == 0) begin
            errors++;
            $display("node %0d received a packet not sent to it, source field %0d", n, src);
         end else begin
            check_flit(name, f, exp_q[n*nodes + src].pop_front());
            if (f.kind == noc_flit_pkg::flit_head) cur_src[n] = src;
            else rx_pkts++;
         end
      end else begin
         q = n*nodes + cur_src[n];
         if (exp_q[q].size() == 0) begin
            errors++;
            $display("node %0d received more flits than node %0d sent", n, cur_src[n]);
         end else begin
            check_flit(name, f, exp_q[q].pop_front());
         end
         if (f.kind == noc_flit_pkg::flit_tail || f.kind == noc_flit_pkg::flit_single) begin
            cur_src[n] = -1;
            rx_pkts++;
         end
      end
   endtask

   function automatic bit busy();
      bit b;
      b = 1'b0;
      for (int n = 0; n < nodes; n++) begin
         if (send_q[n].size() != 0 || local_in_i[n].valid || cur_src[n] >= 0) b = 1'b1;
      end
      for (int q = 0; q < nodes*nodes; q++) begin
         if (exp_q[q].size() != 0) b = 1'b1;
      end
      return b;
   endfunction

   // Drive on the rising edge
   always @(posedge clk_i) begin
      logic [31:0] pick;
      if (running) begin
         for (int n = 0; n < nodes; n++) begin
            if (fire[n]) void'(send_q[n].pop_front());
            if (send_q[n].size() != 0) local_in_i[n] <= {1'b1, send_q[n][0]};
            else local_in_i[n] <= '0;
            pick = next_bits(2);
            local_out_ready_i[n] <= stall_mask[n][pick[1:0]];
         end
      end
   end

   // Sample in the middle of the cycle
   always @(negedge clk_i) begin
      if (running) begin
         for (int n = 0; n < nodes; n++) begin
            fire[n] = local_in_i[n].valid && local_in_ready_o[n];
            if (held_vld[n]) check_link($sformatf("local_out_o[%0d]", n), local_out_o[n], held[n]);
            if (local_out_o[n].valid && local_out_ready_i[n]) begin
               receive_flit(n, local_out_o[n].flit);
               held_vld[n] = 1'b0;
            end else begin
               held_vld[n] = local_out_o[n].valid;  // Stalled flit must stay put
               held[n]     = local_out_o[n];
            end
         end
      end
   end

   initial begin
      int sent;
      int err0;
      $readmemh("tb/mesh_vectors.txt", vec);
      num_vec     = 0;
      total_flits = 0;
      while (num_vec < 64 && !$isunknown(vec[num_vec])) begin
         total_flits += int'(vec[num_vec][7:4]);
         num_vec++;
      end
      rst_n_i <= 1'b0;
      for (int n = 0; n < nodes; n++) begin
         local_in_i[n]        <= '0;
         local_out_ready_i[n] <= 1'b1;
         stall_mask[n]        = 4'hf;
         cur_src[n]           = -1;
         fire[n]              = 1'b0;
         held_vld[n]          = 1'b0;
      end
      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      err0 = errors;
      for (int n = 0; n < nodes; n++) begin
         check_link($sformatf("local_out_o[%0d]", n), local_out_o[n], '0);
         check_ready($sformatf("local_in_ready_o[%0d]", n), local_in_ready_o[n], 1'b1);
      end
      $display("test 1 %s: %0d errors", test_name[1], errors - err0);
      running = 1'b1;
      for (int g = 2; g <= 6; g++) begin
         err0    = errors;
         rx_pkts = 0;
         load_test(g, sent);
         // Queues only change mid-cycle, so the rising edge sees them settled
         do @(posedge clk_i); while (busy());
         check_count("packets received", rx_pkts, sent);
         $display("test %0d %s: %0d packets, %0d errors", g, test_name[g], sent, errors - err0);
         @(negedge clk_i);
         for (int n = 0; n < nodes; n++) stall_mask[n] = 4'hf;
      end
      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Generous bound of 64 cycles per flit
   initial begin
      #1;
      repeat (total_flits * 64 + 200) @(posedge clk_i);
      $display("timeout, packets still in flight after %0d cycles", total_flits * 64 + 200);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* source/mesh_noc.sv */
`timescale 1ns/10ps
`default_nettype none

module mesh_noc #(
   parameter int xdim       = 2,
   parameter int ydim       = 2,
   parameter int fifo_depth = 4
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  noc_flit_pkg::noc_link_t local_in_i        [xdim*ydim],
   output logic                    local_in_ready_o  [xdim*ydim],
   output noc_flit_pkg::noc_link_t local_out_o       [xdim*ydim],
   input  logic                    local_out_ready_i [xdim*ydim]
);

   localparam int nodes = xdim * ydim;
   localparam int np    = mesh_topo_pkg::num_ports;

   noc_flit_pkg::noc_link_t rt_in        [nodes][np];
   logic                    rt_in_ready  [nodes][np];
   noc_flit_pkg::noc_link_t rt_out       [nodes][np];
   logic                    rt_out_ready [nodes][np];

   for (genvar y = 0; y < ydim; y++) begin : g_row
      for (genvar x = 0; x < xdim; x++) begin : g_col
         localparam int n = x + y * xdim;

         mesh_router #(
            .xdim       (xdim),
            .fifo_depth (fifo_depth),
            .my_x       (x),
            .my_y       (y)
         ) u_router (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .in_i        (rt_in[n]),
            .in_ready_o  (rt_in_ready[n]),
            .out_o       (rt_out[n]),
            .out_ready_i (rt_out_ready[n])
         );

         assign rt_in[n][mesh_topo_pkg::port_local]        = local_in_i[n];
         assign local_in_ready_o[n]                        = rt_in_ready[n][mesh_topo_pkg::port_local];
         assign local_out_o[n]                             = rt_out[n][mesh_topo_pkg::port_local];
         assign rt_out_ready[n][mesh_topo_pkg::port_local] = local_out_ready_i[n];

         if (y < ydim - 1) begin : g_north
            assign rt_in[n][mesh_topo_pkg::port_north]        = rt_out[n+xdim][mesh_topo_pkg::port_south];
            assign rt_out_ready[n][mesh_topo_pkg::port_north] = rt_in_ready[n+xdim][mesh_topo_pkg::port_south];
         end else begin : g_north_edge
            assign rt_in[n][mesh_topo_pkg::port_north]        = '0;
            assign rt_out_ready[n][mesh_topo_pkg::port_north] = 1'b0;
         end

         if (y > 0) begin : g_south
            assign rt_in[n][mesh_topo_pkg::port_south]        = rt_out[n-xdim][mesh_topo_pkg::port_north];
            assign rt_out_ready[n][mesh_topo_pkg::port_south] = rt_in_ready[n-xdim][mesh_topo_pkg::port_north];
         end else begin : g_south_edge
            assign rt_in[n][mesh_topo_pkg::port_south]        = '0;
            assign rt_out_ready[n][mesh_topo_pkg::port_south] = 1'b0;
         end

         if (x < xdim - 1) begin : g_east
            assign rt_in[n][mesh_topo_pkg::port_east]        = rt_out[n+1][mesh_topo_pkg::port_west];
            assign rt_out_ready[n][mesh_topo_pkg::port_east] = rt_in_ready[n+1][mesh_topo_pkg::port_west];
         end else begin : g_east_edge
            assign rt_in[n][mesh_topo_pkg::port_east]        = '0;
            assign rt_out_ready[n][mesh_topo_pkg::port_east] = 1'b0;
         end

         // XY routing never picks a border output
         if (x > 0) begin : g_west
            assign rt_in[n][mesh_topo_pkg::port_west]        = rt_out[n-1][mesh_topo_pkg::port_east];
            assign rt_out_ready[n][mesh_topo_pkg::port_west] = rt_in_ready[n-1][mesh_topo_pkg::port_east];
         end else begin : g_west_edge
            assign rt_in[n][mesh_topo_pkg::port_west]        = '0;
            assign rt_out_ready[n][mesh_topo_pkg::port_west] = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* router/mesh_router.sv */
`timescale 1ns/10ps
`default_nettype none

module mesh_router #(
   parameter int xdim       = 2,
   parameter int fifo_depth = 4,
   parameter int my_x       = 0,
   parameter int my_y       = 0
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  noc_flit_pkg::noc_link_t in_i        [mesh_topo_pkg::num_ports],
   output logic                    in_ready_o  [mesh_topo_pkg::num_ports],
   output noc_flit_pkg::noc_link_t out_o       [mesh_topo_pkg::num_ports],
   input  logic                    out_ready_i [mesh_topo_pkg::num_ports]
);

   localparam int np = mesh_topo_pkg::num_ports;

   noc_flit_pkg::noc_link_t   head  [np];
   mesh_topo_pkg::port_mask_t req   [np];  // Per input
   mesh_topo_pkg::port_mask_t req_t [np];  // Per output
   mesh_topo_pkg::port_mask_t grant [np];  // Per output
   logic [np-1:0]             advance;
   logic [np-1:0]             pop;

   for (genvar i = 0; i < np; i++) begin : g_in
      router_in_buffer #(
         .fifo_depth (fifo_depth)
      ) u_buf (
         .clk_i      (clk_i),
         .rst_n_i    (rst_n_i),
         .in_i       (in_i[i]),
         .in_ready_o (in_ready_o[i]),
         .head_o     (head[i]),
         .pop_i      (pop[i])
      );

      router_route_xy #(
         .xdim (xdim),
         .my_x (my_x),
         .my_y (my_y)
      ) u_route (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .head_i  (head[i]),
         .pop_i   (pop[i]),
         .req_o   (req[i])
      );
   end

   always_comb begin
      pop = '0;
      for (int o = 0; o < np; o++) begin
         for (int i = 0; i < np; i++) begin
            req_t[o][i] = req[i][o];
            pop[i]      = pop[i] | (grant[o][i] & advance[o]);
         end
      end
   end

   for (genvar o = 0; o < np; o++) begin : g_out
      noc_flit_pkg::noc_link_t sel;

      router_out_arbiter u_arb (
         .clk_i     (clk_i),
         .rst_n_i   (rst_n_i),
         .req_i     (req_t[o]),
         .last_i    (sel.flit.kind == noc_flit_pkg::flit_tail ||
                     sel.flit.kind == noc_flit_pkg::flit_single),
         .advance_i (advance[o]),
         .grant_o   (grant[o])
      );

      // Crossbar column
      always_comb begin
         sel = '0;
         for (int i = 0; i < np; i++) begin
            if (grant[o][i]) begin
               sel = head[i];
            end
         end
      end

      assign advance[o] = sel.valid && out_ready_i[o];
      assign out_o[o]   = sel;
   end

endmodule

`default_nettype wire

/* router/router_out_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module router_out_arbiter (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  mesh_topo_pkg::port_mask_t req_i,
   input  logic                      last_i,
   input  logic                      advance_i,
   output mesh_topo_pkg::port_mask_t grant_o
);

   localparam int idx_w = $clog2(mesh_topo_pkg::num_ports);

   logic [idx_w-1:0]          rr_idx;
   logic [idx_w-1:0]          grant_idx;
   logic                      locked;
   mesh_topo_pkg::port_mask_t lock_grant;
   mesh_topo_pkg::port_mask_t rr_pick;

   // First requester at or after the pointer
   always_comb begin : rr_search
      int   idx;
      logic found;
      rr_pick = '0;
      found   = 1'b0;
      for (int i = 0; i < mesh_topo_pkg::num_ports; i++) begin
         idx = (int'(rr_idx) + i) % mesh_topo_pkg::num_ports;
         if (!found && req_i[idx]) begin
            rr_pick[idx] = 1'b1;
            found        = 1'b1;
         end
      end
   end

   assign grant_o = locked ? lock_grant : rr_pick;

   always_comb begin
      grant_idx = '0;
      for (int i = 0; i < mesh_topo_pkg::num_ports; i++) begin
         if (grant_o[i]) begin
            grant_idx = idx_w'(i);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         locked     <= 1'b0;
         lock_grant <= '0;
         rr_idx     <= '0;
      end else if (advance_i) begin
         if (last_i) begin
            locked <= 1'b0;
            // Input after the winner goes first next time
            rr_idx <= (grant_idx == idx_w'(mesh_topo_pkg::num_ports - 1)) ?
                      '0 : grant_idx + 1'b1;
         end else begin
            locked     <= 1'b1; // Head passed, hold until tail
            lock_grant <= grant_o;
         end
      end
   end

endmodule

`default_nettype wire

/* router/router_route_xy.sv */
`timescale 1ns/10ps
`default_nettype none

module router_route_xy #(
   parameter int xdim = 2,
   parameter int my_x = 0,
   parameter int my_y = 0
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  noc_flit_pkg::noc_link_t   head_i,
   input  logic                      pop_i,
   output mesh_topo_pkg::port_mask_t req_o
);

   localparam logic [mesh_topo_pkg::coord_w-1:0] self_x = mesh_topo_pkg::coord_w'(my_x);
   localparam logic [mesh_topo_pkg::coord_w-1:0] self_y = mesh_topo_pkg::coord_w'(my_y);

   logic [noc_flit_pkg::dest_w-1:0]  dest;
   logic [mesh_topo_pkg::coord_w-1:0] dest_x;
   logic [mesh_topo_pkg::coord_w-1:0] dest_y;
   mesh_topo_pkg::port_mask_t         calc_mask;
   mesh_topo_pkg::port_mask_t         held_mask;
   logic                              held_vld;

   // Node number is x + y*xdim
   assign dest   = head_i.flit.data[noc_flit_pkg::dest_w-1:0];
   assign dest_x = mesh_topo_pkg::coord_w'(dest % xdim);
   assign dest_y = mesh_topo_pkg::coord_w'(dest / xdim);

   always_comb begin
      calc_mask = '0;
      if (dest_x > self_x) begin
         calc_mask[mesh_topo_pkg::port_east] = 1'b1;
      end else if (dest_x < self_x) begin
         calc_mask[mesh_topo_pkg::port_west] = 1'b1;
      end else if (dest_y > self_y) begin
         calc_mask[mesh_topo_pkg::port_north] = 1'b1;
      end else if (dest_y < self_y) begin
         calc_mask[mesh_topo_pkg::port_south] = 1'b1;
      end else begin
         calc_mask[mesh_topo_pkg::port_local] = 1'b1;
      end
   end

   // Body and tail flits follow the route of their head
   assign req_o = !head_i.valid ? '0 : (held_vld ? held_mask : calc_mask);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         held_vld  <= 1'b0;
         held_mask <= '0;
      end else if (pop_i) begin
         if (!held_vld && head_i.flit.kind == noc_flit_pkg::flit_head) begin
            held_vld  <= 1'b1;
            held_mask <= calc_mask;
         end else if (head_i.flit.kind == noc_flit_pkg::flit_tail) begin
            held_vld  <= 1'b0; // Packet done
         end
      end
   end

endmodule

`default_nettype wire

/* router/router_in_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module router_in_buffer #(
   parameter int fifo_depth = 4
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  noc_flit_pkg::noc_link_t in_i,
   output logic                    in_ready_o,
   output noc_flit_pkg::noc_link_t head_o,
   input  logic                    pop_i
);

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

   noc_flit_pkg::noc_flit_t mem [fifo_depth];

   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w:0]   count;
   logic             push;
   logic             pop;

   assign in_ready_o = (count != (ptr_w+1)'(fifo_depth)); // Not full
   assign push       = in_i.valid && in_ready_o;
   assign pop        = pop_i && (count != '0);

   assign head_o.valid = (count != '0);
   assign head_o.flit  = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= in_i.flit;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* common/mesh_topo_pkg.sv */
`default_nettype none

package mesh_topo_pkg;

   localparam int num_ports = 5;

   // Width of one mesh coordinate
   localparam int coord_w = 2;

   typedef enum logic [2:0] {
      port_local = 3'd0,
      port_north = 3'd1,
      port_east  = 3'd2,
      port_south = 3'd3,
      port_west  = 3'd4
   } port_e;

   // One bit per port, indexed by port_e
   typedef logic [num_ports-1:0] port_mask_t;

endpackage

`default_nettype wire

/* common/noc_flit_pkg.sv */
`default_nettype none

package noc_flit_pkg;

   localparam int flit_data_w = 32;

   // Destination node sits in the low bits of a head flit
   localparam int dest_w = 4;

   typedef enum logic [1:0] {
      flit_single = 2'b00, // Head and tail in one flit
      flit_head   = 2'b01,
      flit_body   = 2'b10,
      flit_tail   = 2'b11
   } flit_kind_t;

   typedef struct packed {
      flit_kind_t             kind;
      logic [flit_data_w-1:0] data;
   } noc_flit_t;

   // Forward half of a link, ready runs the other way
   typedef struct packed {
      logic      valid;
      noc_flit_t flit;
   } noc_link_t;

endpackage

`default_nettype wire
